// File: source/xbus_pkg.sv
package xbus_pkg;

  // ----------------------------------------
  // 8051 external data bus widths
  // ----------------------------------------

  // 24 bit xdata address space
  localparam int XADDR_W = 24;
  // byte wide data path
  localparam int XDATA_W = 8;

  typedef logic [XADDR_W-1:0] xaddr_t;
  typedef logic [XDATA_W-1:0] xdata_t;

  // ----------------------------------------
  // cpu command
  // ----------------------------------------

  // operation decoded from the two strobes
  typedef enum logic [1:0] {
    op_none,
    op_read,
    op_write
  } xbus_op_e;

  // one cpu transfer request, held by the cpu until ready
  typedef struct packed {
    // address, three bytes
    xaddr_t addr;
    // write data byte
    xdata_t wdata;
    // write strobe
    logic   xdatawr;
    // read strobe
    logic   xdatard;
  } xbus_cmd_t;

endpackage

// File: source/apb_pkg.sv
package apb_pkg;

  // ----------------------------------------
  // apb widths and slave count
  // ----------------------------------------

  localparam int PADDR_W    = 32;
  // apb data follows the byte wide cpu bus
  localparam int PDATA_W    = 8;
  localparam int NUM_SLAVES = 4;

  // one bit per slave
  typedef logic [NUM_SLAVES-1:0] slave_vec_t;

  // ----------------------------------------
  // address map
  // ----------------------------------------

  // upper address byte (bits 23..16) per slave
  // slave i owns one 64 KB region
  localparam logic [NUM_SLAVES-1:0][7:0] SLAVE_BASE = {
    8'h05,
    8'h04,
    8'h03,
    8'h02
  };

  // data access, non-secure, privileged
  localparam logic [2:0] APB_PPROT = 3'b011;
  // single byte lane, always written
  localparam logic       APB_PSTRB = 1'b1;

  // ----------------------------------------
  // transfer state and bus structs
  // ----------------------------------------

  typedef enum logic [1:0] {
    st_idle,
    st_setup,
    st_access
  } apb_state_e;

  // request shared by all slaves
  typedef struct packed {
    logic [PADDR_W-1:0] paddr;
    logic               pwrite;
    logic [PDATA_W-1:0] pwdata;
    logic               penable;
  } apb_req_t;

  // response of a single slave
  typedef struct packed {
    logic               pready;
    logic               pslverr;
    logic [PDATA_W-1:0] prdata;
  } apb_rsp_t;

  typedef apb_rsp_t [NUM_SLAVES-1:0] apb_rsp_vec_t;

endpackage

// File: source/apb_fsm.sv
`timescale 1ns/1ps

module apb_fsm
  import xbus_pkg::*;
  import apb_pkg::*;
(
  input  logic      clk,
  input  logic      resetn,
  input  xbus_cmd_t cmd,
  input  logic      hit,
  input  apb_rsp_t  sel_rsp,
  input  logic      slverr_clr,
  output apb_req_t  apb_req,
  output logic      load_sel,
  output logic      clear_sel,
  output logic      ready,
  output logic      slverr
);

  apb_state_e state;
  apb_state_e state_nxt;
  xbus_op_e   op;
  // setup with an empty select, ends without an apb access
  logic       unmapped;

  // ----------------------------------------
  // cpu command decode
  // ----------------------------------------

  // write wins if the cpu ever raises both strobes
  always_comb begin
    if (cmd.xdatawr) begin
      op = op_write;
    end else if (cmd.xdatard) begin
      op = op_read;
    end else begin
      op = op_none;
    end
  end

  // accept in idle, select is registered by the mux on the same edge
  assign load_sel  = (state == st_idle) && (op != op_none);
  // last access cycle
  assign clear_sel = (state == st_access) && sel_rsp.pready;
  assign unmapped  = (state == st_setup) && !hit;

  // ----------------------------------------
  // transfer state machine
  // ----------------------------------------

  always_comb begin
    state_nxt = state;
    case (state)
      st_idle: begin
        if (load_sel) begin
          state_nxt = st_setup;
        end
      end
      st_setup: begin
        // no slave behind the address, finish here
        state_nxt = hit ? st_access : st_idle;
      end
      st_access: begin
        // wait states stretch access until pready
        if (sel_rsp.pready) begin
          state_nxt = st_idle;
        end
      end
      default: begin
        state_nxt = st_idle;
      end
    endcase
  end

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      state <= st_idle;
    end else begin
      state <= state_nxt;
    end
  end

  // ----------------------------------------
  // apb request register
  // ----------------------------------------

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      apb_req <= '0;
    end else begin
      // address, data and direction held from setup through access
      if (load_sel) begin
        apb_req.paddr  <= {{(PADDR_W-XADDR_W){1'b0}}, cmd.addr};
        apb_req.pwrite <= (op == op_write);
        apb_req.pwdata <= cmd.wdata;
      end
      // penable only rises towards a real slave
      if (state == st_setup) begin
        apb_req.penable <= hit;
      end else if (clear_sel) begin
        apb_req.penable <= 1'b0;
      end
    end
  end

  // ----------------------------------------
  // cpu ready
  // ----------------------------------------

  always_comb begin
    case (state)
      st_idle:   ready = (op == op_none);
      st_setup:  ready = !hit;
      st_access: ready = sel_rsp.pready;
      default:   ready = 1'b0;
    endcase
  end

  // sticky error, clear input has priority
  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      slverr <= 1'b0;
    end else if (slverr_clr) begin
      slverr <= 1'b0;
    end else if (unmapped) begin
      slverr <= 1'b1;
    end else if (clear_sel && sel_rsp.pslverr) begin
      slverr <= 1'b1;
    end
  end

endmodule

// File: source/apb_slave_mux.sv
`timescale 1ns/1ps

module apb_slave_mux
  import xbus_pkg::*;
  import apb_pkg::*;
(
  input  logic         clk,
  input  logic         resetn,
  input  xaddr_t       addr,
  input  logic         load_sel,
  input  logic         clear_sel,
  input  apb_rsp_vec_t rsp,
  output slave_vec_t   psel,
  output logic         hit,
  output apb_rsp_t     sel_rsp,
  output xdata_t       rdata
);

  // select decoded straight from the cpu address
  slave_vec_t dec_sel;

  // ----------------------------------------
  // address decode
  // ----------------------------------------

  // compare upper byte against each region
  always_comb begin
    for (int i = 0; i < NUM_SLAVES; i++) begin
      dec_sel[i] = (addr[XADDR_W-1 -: 8] == SLAVE_BASE[i]);
    end
  end

  // one-hot select, loaded on accept, dropped after the last access cycle
  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      psel <= '0;
    end else if (load_sel) begin
      psel <= dec_sel;
    end else if (clear_sel) begin
      psel <= '0;
    end
  end

  // empty select means unmapped
  assign hit = |psel;

  // ----------------------------------------
  // response mux
  // ----------------------------------------

  // and-or mux, all zero when nothing selected
  always_comb begin
    sel_rsp = '0;
    for (int i = 0; i < NUM_SLAVES; i++) begin
      sel_rsp = sel_rsp | (rsp[i] & {$bits(apb_rsp_t){psel[i]}});
    end
  end

  // read data only while the slave completes
  assign rdata = sel_rsp.pready ? sel_rsp.prdata : '0;

endmodule

// File: source/xbus_apb_bridge.sv
`timescale 1ns/1ps

module xbus_apb_bridge
  import xbus_pkg::*;
  import apb_pkg::*;
(
  input  logic         clk,
  input  logic         resetn,
  // cpu side
  input  xbus_cmd_t    cmd,
  output logic         ready,
  output xdata_t       rdata,
  // apb side
  output apb_req_t     apb_req,
  output slave_vec_t   psel,
  output logic [2:0]   pprot,
  output logic         pstrb,
  input  apb_rsp_vec_t rsp,
  // error interrupt
  input  logic         slverr_clr,
  output logic         slverr
);

  logic     load_sel;
  logic     clear_sel;
  logic     hit;
  apb_rsp_t sel_rsp;

  // fixed attributes on every transfer
  assign pprot = APB_PPROT;
  assign pstrb = APB_PSTRB;

  // sequencing, request and cpu handshake
  apb_fsm u_fsm (
    .clk        (clk),
    .resetn     (resetn),
    .cmd        (cmd),
    .hit        (hit),
    .sel_rsp    (sel_rsp),
    .slverr_clr (slverr_clr),
    .apb_req    (apb_req),
    .load_sel   (load_sel),
    .clear_sel  (clear_sel),
    .ready      (ready),
    .slverr     (slverr)
  );

  // decode and response select
  apb_slave_mux u_mux (
    .clk       (clk),
    .resetn    (resetn),
    .addr      (cmd.addr),
    .load_sel  (load_sel),
    .clear_sel (clear_sel),
    .rsp       (rsp),
    .psel      (psel),
    .hit       (hit),
    .sel_rsp   (sel_rsp),
    .rdata     (rdata)
  );

endmodule

// File: dv/xbus_apb_checker.sv
`timescale 1ns/1ps

module xbus_apb_checker
  import apb_pkg::*;
(
  input logic         clk,
  input logic         resetn,
  input logic         ready,
  input apb_req_t     apb_req,
  input slave_vec_t   psel,
  input apb_rsp_vec_t rsp
);

  // pready of whichever slave is selected
  logic sel_ready;
  // select set, enable not yet, i.e. the setup cycle of a mapped transfer
  logic in_setup;

  always_comb begin
    sel_ready = 1'b0;
    for (int i = 0; i < NUM_SLAVES; i++) begin
      sel_ready = sel_ready | (psel[i] & rsp[i].pready);
    end
  end

  assign in_setup = (psel != '0) && !apb_req.penable;

  // ----------------------------------------
  // apb protocol properties
  // ----------------------------------------

  psel_onehot: assert property (@(posedge clk) disable iff (!resetn)
    $onehot0(psel))
    else $error("psel has more than one bit set");

  penable_needs_psel: assert property (@(posedge clk) disable iff (!resetn)
    apb_req.penable |-> (psel != '0))
    else $error("penable high without any psel");

  // request frozen from setup until the slave takes it
  req_stable: assert property (@(posedge clk) disable iff (!resetn)
    (psel != '0) && !(apb_req.penable && sel_ready) |=>
      $stable(apb_req.paddr) && $stable(apb_req.pwrite) &&
      $stable(apb_req.pwdata) && $stable(psel))
    else $error("apb request changed before pready");

  no_ready_in_setup: assert property (@(posedge clk) disable iff (!resetn)
    in_setup |-> !ready)
    else $error("cpu ready high during a mapped setup cycle");

endmodule

bind xbus_apb_bridge xbus_apb_checker u_checker (
  .clk     (clk),
  .resetn  (resetn),
  .ready   (ready),
  .apb_req (apb_req),
  .psel    (psel),
  .rsp     (rsp)
);

// File: dv/tb_xbus_apb_bridge.sv
`timescale 1ns/1ps

module tb_xbus_apb_bridge
  import xbus_pkg::*;
  import apb_pkg::*;
();

  logic         clk = 1'b0;
  logic         resetn;
  xbus_cmd_t    cmd;
  logic         ready;
  xdata_t       rdata;
  apb_req_t     apb_req;
  slave_vec_t   psel;
  logic [2:0]   pprot;
  logic         pstrb;
  apb_rsp_vec_t rsp = '0;
  logic         slverr_clr;
  logic         slverr;

  integer       seed = 32'hef3adbda;
  // slave memories and the model's own copy
  xdata_t       mem [NUM_SLAVES][256];
  xdata_t       shadow [NUM_SLAVES][256];
  int           wait_cnt [NUM_SLAVES];
  // choices for the next transfer, seen by the slave models
  int           cur_wait;
  logic         cur_err;
  // model of the sticky error flag
  logic         exp_slverr;
  int           n_checks;
  int           n_fail;
  xaddr_t       wr_addrs[$];

  always #2 clk = ~clk;

  xbus_apb_bridge DUT (
    .clk        (clk),
    .resetn     (resetn),
    .cmd        (cmd),
    .ready      (ready),
    .rdata      (rdata),
    .apb_req    (apb_req),
    .psel       (psel),
    .pprot      (pprot),
    .pstrb      (pstrb),
    .rsp        (rsp),
    .slverr_clr (slverr_clr),
    .slverr     (slverr)
  );

  // ----------------------------------------
  // address map and random helpers
  // ----------------------------------------

  // upper bytes 0x02..0x05 belong to slaves 0..3
  function automatic int slave_of(input xaddr_t a);
    if (a[23:16] >= 8'h02 && a[23:16] <= 8'h05) begin
      return int'(a[23:16]) - 2;
    end
    return -1;
  endfunction

  // power-up content, mixes slave and offset
  function automatic xdata_t fill_byte(input int s, input int a);
    return xdata_t'(a * 7 + s * 85 + 17);
  endfunction

  function automatic xaddr_t rand_mapped();
    logic [31:0] r;
    r = $random(seed);
    return {8'h02 + {6'b0, r[25:24]}, r[15:0]};
  endfunction

  function automatic xaddr_t rand_unmapped();
    logic [31:0] r;
    logic [7:0]  upper;
    r = $random(seed);
    upper = r[31:24];
    // push mapped bytes out of the map
    if (upper >= 8'h02 && upper <= 8'h05) begin
      upper = upper + 8'h10;
    end
    return {upper, r[15:0]};
  endfunction

  function automatic xdata_t rand_byte();
    logic [31:0] r;
    r = $random(seed);
    return r[7:0];
  endfunction

  // ----------------------------------------
  // apb slave models
  // ----------------------------------------

  always @(negedge clk) begin
    for (int i = 0; i < NUM_SLAVES; i++) begin
      if (!resetn) begin
        rsp[i] = '0;
        wait_cnt[i] = 0;
        for (int a = 0; a < 256; a++) begin
          mem[i][a] = fill_byte(i, a);
        end
      end else if (psel[i] && !apb_req.penable) begin
        // setup, load wait states
        wait_cnt[i] = cur_wait;
        rsp[i] = '0;
      end else if (psel[i] && wait_cnt[i] > 0) begin
        wait_cnt[i]--;
        rsp[i] = '0;
      end else if (psel[i]) begin
        rsp[i].pready  = 1'b1;
        rsp[i].pslverr = cur_err;
        rsp[i].prdata  = apb_req.pwrite ? '0 : mem[i][apb_req.paddr[7:0]];
        // failed writes leave memory alone
        if (apb_req.pwrite && !cur_err) begin
          mem[i][apb_req.paddr[7:0]] = apb_req.pwdata;
        end
      end else begin
        rsp[i] = '0;
      end
    end
  end

  // ----------------------------------------
  // compare tasks
  // ----------------------------------------

  task automatic check_data(input string name, input xdata_t exp, input xdata_t act);
    n_checks++;
    if (exp !== act) begin
      n_fail++;
      $display("FAILED %s expected %02h actual %02h", name, exp, act);
    end else begin
      $display("ok     %s", name);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    n_checks++;
    if (exp !== act) begin
      n_fail++;
      $display("FAILED %s expected %0b actual %0b", name, exp, act);
    end else begin
      $display("ok     %s", name);
    end
  endtask

  task automatic check_sel(input string name, input slave_vec_t exp, input slave_vec_t act);
    n_checks++;
    if (exp !== act) begin
      n_fail++;
      $display("FAILED %s expected %04b actual %04b", name, exp, act);
    end else begin
      $display("ok     %s", name);
    end
  endtask

  task automatic check_prot(input string name, input logic [2:0] exp, input logic [2:0] act);
    n_checks++;
    if (exp !== act) begin
      n_fail++;
      $display("FAILED %s expected %03b actual %03b", name, exp, act);
    end else begin
      $display("ok     %s", name);
    end
  endtask

  // ----------------------------------------
  // cpu bus driver
  // ----------------------------------------

  // sampled 1 ns after the falling edge, values seen by the next rising edge
  task automatic wait_ready(input string name);
    int cycles;
    cycles = 0;
    #1;
    while (!ready && cycles < 64) begin
      cycles++;
      @(negedge clk);
      #1;
    end
    if (!ready) begin
      $display("ERROR ready never rose within 64 cycles, bridge hung on %s", name);
      $display("TESTS FAILED");
      $finish;
    end
  endtask

  task automatic xfer(input xbus_op_e op, input xaddr_t addr, input xdata_t wdata,
                      input string name, output xdata_t rd, output slave_vec_t sel);
    @(negedge clk);
    cmd.addr    = addr;
    cmd.wdata   = wdata;
    cmd.xdatawr = (op == op_write);
    cmd.xdatard = (op == op_read);
    wait_ready(name);
    rd  = rdata;
    sel = psel;
    // strobes drop on the falling edge after the completing edge
    @(negedge clk);
    cmd.xdatawr = 1'b0;
    cmd.xdatard = 1'b0;
    #1;
  endtask

  // one transfer against the reference model
  task automatic check_xfer(input xbus_op_e op, input xaddr_t addr, input xdata_t wdata,
                            input logic err, input int waits, input string name);
    int         s;
    xdata_t     rd;
    slave_vec_t sel;
    s = slave_of(addr);
    cur_wait = waits;
    cur_err  = err;
    xfer(op, addr, wdata, name, rd, sel);
    check_sel({name, " psel"}, (s < 0) ? '0 : slave_vec_t'(1 << s), sel);
    if (op == op_read) begin
      check_data(name, (s < 0) ? '0 : shadow[s][addr[7:0]], rd);
    end
    if (op == op_write && s >= 0 && !err) begin
      shadow[s][addr[7:0]] = wdata;
    end
    // unmapped always flags, a slave error flags too, nothing else clears it
    if (s < 0 || err) begin
      exp_slverr = 1'b1;
    end
    check_flag({name, " slverr"}, exp_slverr, slverr);
  endtask

  // one cycle pulse on the clear input
  task automatic clear_slverr(input string name);
    @(negedge clk);
    slverr_clr = 1'b1;
    @(negedge clk);
    slverr_clr = 1'b0;
    exp_slverr = 1'b0;
    #1;
    check_flag(name, exp_slverr, slverr);
  endtask

  // ----------------------------------------
  // test sequence
  // ----------------------------------------

  initial begin
    logic [31:0] r;
    xaddr_t      a;
    xbus_op_e    op;
    resetn     = 1'b0;
    cmd        = '0;
    slverr_clr = 1'b0;
    cur_wait   = 0;
    cur_err    = 1'b0;
    exp_slverr = 1'b0;
    n_checks   = 0;
    n_fail     = 0;
    for (int s = 0; s < NUM_SLAVES; s++) begin
      for (int o = 0; o < 256; o++) begin
        shadow[s][o] = fill_byte(s, o);
      end
    end
    repeat (16) @(posedge clk);
    @(negedge clk);
    resetn = 1'b1;
    #1;

    // idle after reset
    check_flag("reset ready", 1'b1, ready);
    check_sel("reset psel", '0, psel);
    check_flag("reset penable", 1'b0, apb_req.penable);
    check_flag("reset slverr", 1'b0, slverr);
    // data access, non-secure, privileged, one byte lane
    check_prot("pprot", 3'b011, pprot);
    check_flag("pstrb", 1'b1, pstrb);

    // writes, then read back, no wait states
    for (int k = 0; k < 24; k++) begin
      a = rand_mapped();
      wr_addrs.push_back(a);
      check_xfer(op_write, a, rand_byte(), 1'b0, 0, $sformatf("wr %06h", a));
    end
    foreach (wr_addrs[k]) begin
      check_xfer(op_read, wr_addrs[k], 8'h00, 1'b0, 0, $sformatf("rd %06h", wr_addrs[k]));
    end

    // mixed traffic, 0..3 wait states, rare slave error
    for (int k = 0; k < 40; k++) begin
      r  = $random(seed);
      op = r[0] ? op_write : op_read;
      a  = rand_mapped();
      check_xfer(op, a, r[15:8], r[18:16] == 3'd0, int'(r[5:4]),
                 $sformatf("%s %06h", op.name(), a));
      // rearm so the next error is visible
      if (exp_slverr) begin
        clear_slverr($sformatf("clear after %06h", a));
      end
    end

    // unmapped region, no hang
    for (int k = 0; k < 4; k++) begin
      a = rand_unmapped();
      clear_slverr("clear before unmapped rd");
      check_xfer(op_read, a, 8'h00, 1'b0, 0, $sformatf("unmapped rd %06h", a));
      clear_slverr("clear before unmapped wr");
      check_xfer(op_write, a, rand_byte(), 1'b0, 0, $sformatf("unmapped wr %06h", a));
    end

    // slave error holds across a clean transfer, clear, then a clean transfer
    a = rand_mapped();
    check_xfer(op_write, a, 8'h5a, 1'b1, 1, "error wr");
    check_xfer(op_read, a, 8'h00, 1'b0, 0, "sticky rd");
    clear_slverr("slverr clear");
    check_xfer(op_read, a, 8'h00, 1'b0, 2, "clean rd");
    check_xfer(op_read, a, 8'h00, 1'b1, 0, "error rd");

    $display("checks: %0d run, %0d failed", n_checks, n_fail);
    if (n_fail == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: vlog.f
source/xbus_pkg.sv
source/apb_pkg.sv
source/apb_fsm.sv
source/apb_slave_mux.sv
source/xbus_apb_bridge.sv
dv/xbus_apb_checker.sv
dv/tb_xbus_apb_bridge.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove build directory and log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f vlog.f \
	  --top-module tb_xbus_apb_bridge -Mdir obj_dir -o sim_tb
	./obj_dir/sim_tb > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "TESTS FAILED" sim.log; then \
	  echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
